// File: sim.f
+incdir+source
source/scaler_pkg.sv
source/scale_step.sv
source/frame_control.sv
source/line_fetch.sv
source/line_buffer.sv
source/pixel_stream.sv
source/mm2s_scaler.sv
testbench/tb_memory_model.sv
testbench/tb_mm2s_scaler.sv

// File: source/frame_control.sv
`timescale 1ns/1ns
`include "scaler_config.svh"

module frame_control (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic                  fsync,
	input  scaler_pkg::col_t      win_left,
	input  scaler_pkg::col_t      win_width,
	input  scaler_pkg::row_t      win_top,
	input  scaler_pkg::row_t      win_height,
	input  scaler_pkg::row_t      dst_height,
	input  scaler_pkg::addr_t     frame_addr,
	input  logic [`BUF_NUM-1:0]   full,
	input  logic                  line_done,
	output logic                  line_start,
	output scaler_pkg::addr_t     line_addr,
	output scaler_pkg::wr_index_t line_words,
	output scaler_pkg::col_t      read_offset,
	output logic [`BUF_NUM-1:0]   wr_owner,
	output logic                  frame_read_done
);
	localparam scaler_pkg::col_t BURST_MASK = scaler_pkg::col_t'(`BURST_PIXELS - 1);
	localparam int WORD_SHIFT = $clog2(`WORD_PIXELS);

	scaler_pkg::frame_state_t state;
	scaler_pkg::addr_t base_addr;
	scaler_pkg::row_t top_r;
	scaler_pkg::row_t src_rows;
	scaler_pkg::row_t dst_rows;
	scaler_pkg::row_t row_index;
	scaler_pkg::row_t row_sum;
	logic [`IMG_WBITS:0] fetch_span;
	logic fsync_d1;
	logic row_valid;
	logic row_ready;
	logic row_last;
	logic row_take;
	logic last_row;
	logic owned_full;

	// read offset plus window width, rounded up to whole words below
	assign fetch_span = {1'b0, win_left & BURST_MASK} + {1'b0, win_width}
		+ (`IMG_WBITS + 1)'(`WORD_PIXELS - 1);

	assign owned_full = |(full & wr_owner);
	assign row_ready = (state == scaler_pkg::FRAME_WAIT_BUF) && !owned_full;
	assign row_take = row_valid && row_ready;
	assign row_sum = top_r + row_index;
	assign frame_read_done = (state == scaler_pkg::FRAME_FETCH) && line_done && last_row;

	scale_step #(
		.WIDTH(`IMG_HBITS)
	) i_row_step (
		.clk(clk),
		.resetn(resetn),
		.start(fsync_d1),
		.src_len(src_rows),
		.dst_len(dst_rows),
		.valid(row_valid),
		.ready(row_ready),
		.index(row_index),
		.last(row_last)
	);

	// geometry taken at frame sync
	always_ff @(posedge clk) begin
		if (fsync) begin
			base_addr <= frame_addr + scaler_pkg::addr_t'(win_left & ~BURST_MASK);
			top_r <= win_top;
			src_rows <= win_height;
			dst_rows <= dst_height;
			line_words <= fetch_span[`IMG_WBITS-1:WORD_SHIFT];
			read_offset <= win_left & BURST_MASK;
		end
		if (row_take)
			line_addr <= base_addr + (scaler_pkg::addr_t'(row_sum) << `STRIDE_WIDTH);
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= scaler_pkg::FRAME_IDLE;
			fsync_d1 <= 1'b0;
			line_start <= 1'b0;
			last_row <= 1'b0;
			wr_owner <= `BUF_NUM'(1);
		end else begin
			fsync_d1 <= fsync;
			line_start <= 1'b0;
			if (fsync) begin
				state <= scaler_pkg::FRAME_IDLE;
				wr_owner <= `BUF_NUM'(1);
			end else if (fsync_d1) begin
				state <= scaler_pkg::FRAME_WAIT_BUF;
			end else begin
				case (state)
					scaler_pkg::FRAME_WAIT_BUF: begin
						if (row_take) begin
							line_start <= 1'b1;
							last_row <= row_last;
							state <= scaler_pkg::FRAME_FETCH;
						end
					end
					scaler_pkg::FRAME_FETCH: begin
						if (line_done) begin
							wr_owner <= {wr_owner[`BUF_NUM-2:0], wr_owner[`BUF_NUM-1]};
							if (last_row)
								state <= scaler_pkg::FRAME_IDLE;
							else
								state <= scaler_pkg::FRAME_WAIT_BUF;
						end
					end
					default: state <= scaler_pkg::FRAME_IDLE;
				endcase
			end
		end
	end

	// the streamer must have drained the target buffer before a fetch starts
	assert property (@(posedge clk) disable iff (!resetn) line_start |-> !owned_full)
		else $error("line fetch started into a full buffer");

endmodule

// File: source/line_buffer.sv
`timescale 1ns/1ns
`include "scaler_config.svh"

module line_buffer (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic                  fsync,
	input  logic                  wr_owner,
	input  logic                  wr_en,
	input  scaler_pkg::wr_index_t wr_addr,
	input  scaler_pkg::word_t     wr_data,
	input  logic                  line_done,
	input  logic                  rd_owner,
	input  logic                  rd_en,
	input  scaler_pkg::col_t      rd_addr,
	input  logic                  rd_done,
	output scaler_pkg::pixel_t    rd_data,
	output logic                  full
);
	localparam int SEL_BITS = $clog2(`WORD_PIXELS);
	localparam int DEPTH = 2 ** (`IMG_WBITS - SEL_BITS);

	scaler_pkg::word_t mem [DEPTH];
	scaler_pkg::word_t rd_word;
	logic [SEL_BITS-1:0] rd_sel;

	// upper address bits pick the word, low bits the pixel in it
	assign rd_word = mem[rd_addr[`IMG_WBITS-1:SEL_BITS]];
	assign rd_sel = rd_addr[SEL_BITS-1:0];

	always_ff @(posedge clk) begin
		if (wr_owner && wr_en)
			mem[wr_addr] <= wr_data;
		if (rd_owner && rd_en)
			rd_data <= rd_word[rd_sel*`PIXEL_WIDTH +: `PIXEL_WIDTH];
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			full <= 1'b0;
		else if (fsync)
			full <= 1'b0;
		else if (wr_owner && line_done)
			full <= 1'b1;
		else if (rd_owner && rd_done)
			full <= 1'b0;
	end

	// the fetcher must never overwrite a line the streamer has not drained
	assert property (@(posedge clk) disable iff (!resetn) wr_owner && wr_en |-> !full)
		else $error("write into a full line buffer");

endmodule

// File: source/line_fetch.sv
`timescale 1ns/1ns
`include "scaler_config.svh"

module line_fetch (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic                  line_start,
	input  scaler_pkg::addr_t     line_addr,
	input  scaler_pkg::wr_index_t line_words,
	output scaler_pkg::addr_t     araddr,
	output logic [7:0]            arlen,
	output logic                  arvalid,
	input  logic                  arready,
	input  scaler_pkg::word_t     rdata,
	input  logic                  rlast,
	input  logic                  rvalid,
	output logic                  rready,
	output logic                  wr_en,
	output scaler_pkg::wr_index_t wr_addr,
	output scaler_pkg::word_t     wr_data,
	output logic                  line_done
);
	localparam int BURST_BYTES = `BURST_LEN * `DATA_WIDTH / 8;

	scaler_pkg::fetch_state_t state;
	scaler_pkg::wr_index_t words_left;
	scaler_pkg::wr_index_t wr_ptr;

	// full burst unless the line ends sooner
	function automatic logic [7:0] burst_arlen(input scaler_pkg::wr_index_t words);
		if (words > scaler_pkg::wr_index_t'(`BURST_LEN))
			return 8'(`BURST_LEN - 1);
		return 8'(words - 1'b1);
	endfunction

	// a buffer is only written while empty, so no back-pressure on R
	assign rready = state == scaler_pkg::FETCH_DATA;
	assign wr_en = rvalid && rready;
	assign wr_addr = wr_ptr;
	assign wr_data = rdata;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= scaler_pkg::FETCH_IDLE;
			arvalid <= 1'b0;
			line_done <= 1'b0;
		end else begin
			line_done <= 1'b0;
			case (state)
				scaler_pkg::FETCH_IDLE: begin
					if (line_start) begin
						arvalid <= 1'b1;
						state <= scaler_pkg::FETCH_ADDR;
					end
				end
				scaler_pkg::FETCH_ADDR: begin
					if (arready) begin
						arvalid <= 1'b0;
						state <= scaler_pkg::FETCH_DATA;
					end
				end
				scaler_pkg::FETCH_DATA: begin
					if (rvalid && rlast) begin
						if (words_left == '0) begin
							line_done <= 1'b1;
							state <= scaler_pkg::FETCH_IDLE;
						end else begin
							arvalid <= 1'b1;
							state <= scaler_pkg::FETCH_ADDR;
						end
					end
				end
				default: state <= scaler_pkg::FETCH_IDLE;
			endcase
		end
	end

	// burst address, length and write pointer
	always_ff @(posedge clk) begin
		case (state)
			scaler_pkg::FETCH_IDLE: begin
				if (line_start) begin
					araddr <= line_addr;
					arlen <= burst_arlen(line_words);
					words_left <= line_words;
					wr_ptr <= '0;
				end
			end
			scaler_pkg::FETCH_ADDR: begin
				if (arready)
					words_left <= words_left - scaler_pkg::wr_index_t'(arlen) - 1'b1;
			end
			scaler_pkg::FETCH_DATA: begin
				if (rvalid) begin
					wr_ptr <= wr_ptr + 1'b1;
					if (rlast && words_left != '0) begin
						araddr <= araddr + scaler_pkg::addr_t'(BURST_BYTES);
						arlen <= burst_arlen(words_left);
					end
				end
			end
			default: ;
		endcase
	end

	assert property (@(posedge clk) disable iff (!resetn)
		arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
		else $error("AR request changed before it was accepted");

endmodule

// File: source/mm2s_scaler.sv
`timescale 1ns/1ns
`include "scaler_config.svh"

module mm2s_scaler (
	input  logic               clk,
	input  logic               resetn,
	input  scaler_pkg::col_t   win_left,
	input  scaler_pkg::col_t   win_width,
	input  scaler_pkg::row_t   win_top,
	input  scaler_pkg::row_t   win_height,
	input  scaler_pkg::col_t   dst_width,
	input  scaler_pkg::row_t   dst_height,
	input  scaler_pkg::addr_t  frame_addr,
	input  logic               fsync,
	output logic               frame_read_done,
	output scaler_pkg::addr_t  araddr,
	output logic [7:0]         arlen,
	output logic               arvalid,
	input  logic               arready,
	input  scaler_pkg::word_t  rdata,
	input  logic               rlast,
	input  logic               rvalid,
	output logic               rready,
	output logic               tvalid,
	output scaler_pkg::pixel_t tdata,
	output logic               tuser,
	output logic               tlast,
	input  logic               tready
);
	scaler_pkg::addr_t line_addr;
	scaler_pkg::wr_index_t line_words;
	scaler_pkg::col_t read_offset;
	scaler_pkg::wr_index_t wr_addr;
	scaler_pkg::word_t wr_data;
	scaler_pkg::col_t rd_addr;
	scaler_pkg::pixel_t [`BUF_NUM-1:0] rd_data;
	logic [`BUF_NUM-1:0] full;
	logic [`BUF_NUM-1:0] wr_owner;
	logic [`BUF_NUM-1:0] rd_owner;
	logic line_start;
	logic line_done;
	logic wr_en;
	logic rd_en;
	logic rd_done;

	frame_control i_frame_control (
		.clk(clk), .resetn(resetn), .fsync(fsync),
		.win_left(win_left), .win_width(win_width),
		.win_top(win_top), .win_height(win_height),
		.dst_height(dst_height), .frame_addr(frame_addr),
		.full(full), .line_done(line_done),
		.line_start(line_start), .line_addr(line_addr), .line_words(line_words),
		.read_offset(read_offset), .wr_owner(wr_owner),
		.frame_read_done(frame_read_done)
	);

	line_fetch i_line_fetch (
		.clk(clk), .resetn(resetn),
		.line_start(line_start), .line_addr(line_addr), .line_words(line_words),
		.araddr(araddr), .arlen(arlen), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rlast(rlast), .rvalid(rvalid), .rready(rready),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .line_done(line_done)
	);

	// ping-pong line stores sharing the write and read buses
	for (genvar i = 0; i < `BUF_NUM; i++) begin : g_buf
		line_buffer i_line_buffer (
			.clk(clk), .resetn(resetn), .fsync(fsync),
			.wr_owner(wr_owner[i]), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
			.line_done(line_done),
			.rd_owner(rd_owner[i]), .rd_en(rd_en), .rd_addr(rd_addr), .rd_done(rd_done),
			.rd_data(rd_data[i]), .full(full[i])
		);
	end

	pixel_stream i_pixel_stream (
		.clk(clk), .resetn(resetn), .fsync(fsync),
		.win_width(win_width), .dst_width(dst_width), .read_offset(read_offset),
		.full(full), .rd_owner(rd_owner), .rd_en(rd_en), .rd_addr(rd_addr),
		.rd_done(rd_done), .rd_data(rd_data),
		.tvalid(tvalid), .tdata(tdata), .tuser(tuser), .tlast(tlast), .tready(tready)
	);

endmodule

// File: source/pixel_stream.sv
`timescale 1ns/1ns
`include "scaler_config.svh"

module pixel_stream (
	input  logic                                  clk,
	input  logic                                  resetn,
	input  logic                                  fsync,
	input  scaler_pkg::col_t                      win_width,
	input  scaler_pkg::col_t                      dst_width,
	input  scaler_pkg::col_t                      read_offset,
	input  logic [`BUF_NUM-1:0]                   full,
	output logic [`BUF_NUM-1:0]                   rd_owner,
	output logic                                  rd_en,
	output scaler_pkg::col_t                      rd_addr,
	output logic                                  rd_done,
	input  scaler_pkg::pixel_t [`BUF_NUM-1:0]     rd_data,
	output logic                                  tvalid,
	output scaler_pkg::pixel_t                    tdata,
	output logic                                  tuser,
	output logic                                  tlast,
	input  logic                                  tready
);
	scaler_pkg::pixel_state_t state;
	scaler_pkg::col_t src_cols;
	scaler_pkg::col_t dst_cols;
	scaler_pkg::col_t col_index;
	scaler_pkg::pixel_t s1_pixel;
	logic [`BUF_NUM-1:0] s1_owner;
	logic col_valid;
	logic col_ready;
	logic col_last;
	logic advance;
	logic s1_valid;
	logic s1_last;

	// stage 1 is the buffer read, stage 2 the output register
	assign advance = !tvalid || tready;
	assign col_ready = (state == scaler_pkg::PIX_RUN) && (!s1_valid || advance);
	assign rd_en = col_valid && col_ready;
	assign rd_addr = read_offset + col_index;
	assign rd_done = tvalid && tready && tlast;

	always_comb begin
		s1_pixel = rd_data[0];
		for (int i = 0; i < `BUF_NUM; i++)
			if (s1_owner[i])
				s1_pixel = rd_data[i];
	end

	scale_step #(
		.WIDTH(`IMG_WBITS)
	) i_col_step (
		.clk(clk),
		.resetn(resetn),
		.start(state == scaler_pkg::PIX_START),
		.src_len(src_cols),
		.dst_len(dst_cols),
		.valid(col_valid),
		.ready(col_ready),
		.index(col_index),
		.last(col_last)
	);

	always_ff @(posedge clk) begin
		if (fsync) begin
			src_cols <= win_width;
			dst_cols <= dst_width;
		end
		if (rd_en) begin
			s1_owner <= rd_owner;
			s1_last <= col_last;
		end
		if (advance && s1_valid)
			tdata <= s1_pixel;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= scaler_pkg::PIX_IDLE;
			rd_owner <= `BUF_NUM'(1);
			s1_valid <= 1'b0;
			tvalid <= 1'b0;
			tuser <= 1'b0;
			tlast <= 1'b0;
		end else if (fsync) begin
			state <= scaler_pkg::PIX_IDLE;
			rd_owner <= `BUF_NUM'(1);
			s1_valid <= 1'b0;
			tvalid <= 1'b0;
			tuser <= 1'b1;
			tlast <= 1'b0;
		end else begin
			case (state)
				scaler_pkg::PIX_IDLE: begin
					if (|(full & rd_owner))
						state <= scaler_pkg::PIX_START;
				end
				scaler_pkg::PIX_START: state <= scaler_pkg::PIX_RUN;
				// stay until the last pixel has left the output register
				scaler_pkg::PIX_RUN: begin
					if (rd_done)
						state <= scaler_pkg::PIX_IDLE;
				end
				default: state <= scaler_pkg::PIX_IDLE;
			endcase
			if (rd_done)
				rd_owner <= {rd_owner[`BUF_NUM-2:0], rd_owner[`BUF_NUM-1]};
			if (rd_en)
				s1_valid <= 1'b1;
			else if (advance)
				s1_valid <= 1'b0;
			if (advance) begin
				tvalid <= s1_valid;
				if (s1_valid)
					tlast <= s1_last;
			end
			if (tvalid && tready)
				tuser <= 1'b0;
		end
	end

	assert property (@(posedge clk) disable iff (!resetn)
		tvalid && !tready && !fsync |=>
			tvalid && $stable(tdata) && $stable(tuser) && $stable(tlast))
		else $error("stream output changed under stall");

endmodule

// File: source/scale_step.sv
`timescale 1ns/1ns
`include "scaler_config.svh"

module scale_step #(
	parameter int WIDTH = `IMG_WBITS
) (
	input  logic             clk,
	input  logic             resetn,
	input  logic             start,
	input  logic [WIDTH-1:0] src_len,
	input  logic [WIDTH-1:0] dst_len,
	output logic             valid,
	input  logic             ready,
	output logic [WIDTH-1:0] index,
	output logic             last
);
	// acc holds k*src_len - index*dst_len, one extra bit for the add
	logic [WIDTH:0] acc;
	logic [WIDTH-1:0] count;
	logic busy;
	logic aligned;

	// index is exact once the remainder drops below dst_len
	assign aligned = acc < {1'b0, dst_len};
	assign valid = busy && aligned;
	assign last = count == dst_len - 1'b1;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			busy <= 1'b0;
			acc <= '0;
			index <= '0;
			count <= '0;
		end else if (start) begin
			busy <= 1'b1;
			acc <= '0;
			index <= '0;
			count <= '0;
		end else if (busy) begin
			if (valid && ready) begin
				acc <= acc + {1'b0, src_len};
				count <= count + 1'b1;
				if (last)
					busy <= 1'b0;
			end else if (!aligned) begin
				// one source step per cycle until aligned again
				acc <= acc - {1'b0, dst_len};
				index <= index + 1'b1;
			end
		end
	end

endmodule

// File: source/scaler_config.svh
`ifndef SCALER_CONFIG_SVH
`define SCALER_CONFIG_SVH

// pixel and bus sizes
`define PIXEL_WIDTH 8
`define DATA_WIDTH 32
`define ADDR_WIDTH 32
`define BURST_LEN 16

// image counters
`define IMG_WBITS 12
`define IMG_HBITS 12
// one source line occupies 2**STRIDE_WIDTH bytes
`define STRIDE_WIDTH 10

// line buffering
`define BUF_NUM 2
`define WORD_PIXELS 4
`define BURST_PIXELS 64

`endif

// File: source/scaler_pkg.sv
`include "scaler_config.svh"

package scaler_pkg;

	typedef logic [`PIXEL_WIDTH-1:0] pixel_t;
	typedef logic [`DATA_WIDTH-1:0] word_t;
	typedef logic [`IMG_WBITS-1:0] col_t;
	typedef logic [`IMG_HBITS-1:0] row_t;
	typedef logic [`ADDR_WIDTH-1:0] addr_t;
	// word index inside one line buffer
	typedef logic [`IMG_WBITS-3:0] wr_index_t;

	typedef enum logic [1:0] {FRAME_IDLE, FRAME_WAIT_BUF, FRAME_FETCH} frame_state_t;

	typedef enum logic [1:0] {FETCH_IDLE, FETCH_ADDR, FETCH_DATA} fetch_state_t;

	typedef enum logic [1:0] {PIX_IDLE, PIX_START, PIX_RUN} pixel_state_t;

endpackage

// File: testbench/tb_memory_model.sv
`timescale 1ns/1ns
`include "scaler_config.svh"

module tb_memory_model (
	input  logic              clk,
	input  logic              resetn,
	input  scaler_pkg::addr_t araddr,
	input  logic [7:0]        arlen,
	input  logic              arvalid,
	output logic              arready,
	output scaler_pkg::word_t rdata,
	output logic              rlast,
	output logic              rvalid,
	input  logic              rready
);
	scaler_pkg::addr_t beat_addr;
	int beats_left;
	int delay;
	logic ar_taken;
	logic r_taken;
	logic in_burst;

	// memory image byte at address a
	function automatic logic [7:0] image_byte(input scaler_pkg::addr_t a);
		return 8'(a * 7 + (a >> 10));
	endfunction

	function automatic scaler_pkg::word_t image_word(input scaler_pkg::addr_t a);
		scaler_pkg::word_t w;
		for (int i = 0; i < `WORD_PIXELS; i++)
			w[i*`PIXEL_WIDTH +: `PIXEL_WIDTH] = image_byte(a + i);
		return w;
	endfunction

	initial begin
		arready = 1'b0;
		rvalid = 1'b0;
		rlast = 1'b0;
		rdata = '0;
		in_burst = 1'b0;
		beats_left = 0;
		beat_addr = '0;
		delay = 0;
	end

	// handshakes sampled at the edge, outputs driven 1 ns later
	always begin
		@(posedge clk);
		ar_taken = arvalid && arready;
		r_taken = rvalid && rready;
		if (ar_taken) begin
			beat_addr = araddr;
			beats_left = arlen + 1;
		end
		#1;
		if (!resetn) begin
			arready = 1'b0;
			rvalid = 1'b0;
			rlast = 1'b0;
			in_burst = 1'b0;
		end else begin
			if (ar_taken) begin
				arready = 1'b0;
				in_burst = 1'b1;
				delay = $urandom_range(0, 3);
			end else if (!in_burst && arvalid && !arready) begin
				if (delay == 0)
					arready = 1'b1;
				else
					delay--;
			end
			if (r_taken) begin
				rvalid = 1'b0;
				rlast = 1'b0;
				beat_addr = beat_addr + `WORD_PIXELS;
				beats_left--;
				if (beats_left == 0)
					in_burst = 1'b0;
				delay = $urandom_range(0, 3);
			end
			if (in_burst && !rvalid) begin
				if (delay == 0) begin
					rvalid = 1'b1;
					rdata = image_word(beat_addr);
					rlast = beats_left == 1;
				end else begin
					delay--;
				end
			end
		end
	end

endmodule

// File: testbench/tb_mm2s_scaler.sv
`timescale 1ns/1ns

module tb_mm2s_scaler;

	localparam int N_FRAMES = 6;
	localparam int FRAME_TIMEOUT = 40000;
	localparam int TAIL_CYCLES = 20;

	// identity, downscale, unaligned upscale, stalled downscale, back to back pair
	string frame_name [N_FRAMES] = '{"identity", "downscale", "upscale_unaligned",
		"random_ready", "back_to_back_a", "back_to_back_b"};
	int frame_left [N_FRAMES] = '{0, 128, 70, 128, 200, 13};
	int frame_width [N_FRAMES] = '{32, 100, 60, 100, 48, 20};
	int frame_top [N_FRAMES] = '{0, 5, 2, 5, 10, 1};
	int frame_height [N_FRAMES] = '{4, 40, 3, 40, 6, 5};
	int frame_dst_w [N_FRAMES] = '{32, 37, 90, 37, 24, 50};
	int frame_dst_h [N_FRAMES] = '{4, 15, 7, 15, 3, 9};
	int frame_stall [N_FRAMES] = '{0, 0, 0, 1, 1, 1};
	scaler_pkg::addr_t frame_base [N_FRAMES] = '{32'h0001_0000, 32'h0004_0000,
		32'h0008_0000, 32'h000c_0000, 32'h0010_0000, 32'h0020_0000};

	logic clk;
	logic resetn;
	scaler_pkg::col_t win_left;
	scaler_pkg::col_t win_width;
	scaler_pkg::row_t win_top;
	scaler_pkg::row_t win_height;
	scaler_pkg::col_t dst_width;
	scaler_pkg::row_t dst_height;
	scaler_pkg::addr_t frame_addr;
	logic fsync;
	logic frame_read_done;
	scaler_pkg::addr_t araddr;
	logic [7:0] arlen;
	logic arvalid;
	logic arready;
	scaler_pkg::word_t rdata;
	logic rlast;
	logic rvalid;
	logic rready;
	logic tvalid;
	scaler_pkg::pixel_t tdata;
	logic tuser;
	logic tlast;
	logic tready;

	int cur_frame;
	int frame_pixels;
	int pix_count;
	int done_count;

	mm2s_scaler i_dut (
		.clk(clk), .resetn(resetn),
		.win_left(win_left), .win_width(win_width),
		.win_top(win_top), .win_height(win_height),
		.dst_width(dst_width), .dst_height(dst_height),
		.frame_addr(frame_addr), .fsync(fsync), .frame_read_done(frame_read_done),
		.araddr(araddr), .arlen(arlen), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rlast(rlast), .rvalid(rvalid), .rready(rready),
		.tvalid(tvalid), .tdata(tdata), .tuser(tuser), .tlast(tlast), .tready(tready)
	);

	tb_memory_model i_memory (
		.clk(clk), .resetn(resetn),
		.araddr(araddr), .arlen(arlen), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rlast(rlast), .rvalid(rvalid), .rready(rready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic scaler_pkg::pixel_t source_byte(input scaler_pkg::addr_t a);
		return 8'(a * 7 + (a >> 10));
	endfunction

	// nearest neighbour source pixel by the floor rule
	function automatic scaler_pkg::pixel_t expected_pixel(input int s, input int r, input int c);
		int src_row;
		int src_col;
		scaler_pkg::addr_t a;
		src_row = frame_top[s] + r * frame_height[s] / frame_dst_h[s];
		src_col = frame_left[s] + c * frame_width[s] / frame_dst_w[s];
		a = frame_base[s] + scaler_pkg::addr_t'(src_row) * 1024 + scaler_pkg::addr_t'(src_col);
		return source_byte(a);
	endfunction

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_pixel(input string name, input scaler_pkg::pixel_t exp,
		input scaler_pkg::pixel_t act);
		if (act !== exp)
			stop_with_error($sformatf("FAIL %s expected %02h actual %02h", name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			stop_with_error($sformatf("FAIL %s expected %0b actual %0b", name, exp, act));
	endtask

	// every accepted pixel is compared against the reference
	always @(posedge clk) begin : compare_output
		int row;
		int col;
		string tag;
		if (resetn && tvalid && tready) begin
			if (pix_count >= frame_pixels)
				stop_with_error("a pixel arrived after the end of the frame");
			row = pix_count / frame_dst_w[cur_frame];
			col = pix_count % frame_dst_w[cur_frame];
			tag = $sformatf("%s r%0d c%0d", frame_name[cur_frame], row, col);
			check_pixel({tag, " tdata"}, expected_pixel(cur_frame, row, col), tdata);
			check_flag({tag, " tuser"}, pix_count == 0, tuser);
			check_flag({tag, " tlast"}, col == frame_dst_w[cur_frame] - 1, tlast);
			pix_count++;
		end
		if (resetn && frame_read_done) begin
			check_flag({frame_name[cur_frame], " extra frame_read_done"}, 1'b0, done_count != 0);
			done_count++;
		end
	end

	task automatic run_frame(input int s);
		int cycles;
		@(posedge clk);
		#1;
		win_left = scaler_pkg::col_t'(frame_left[s]);
		win_width = scaler_pkg::col_t'(frame_width[s]);
		win_top = scaler_pkg::row_t'(frame_top[s]);
		win_height = scaler_pkg::row_t'(frame_height[s]);
		dst_width = scaler_pkg::col_t'(frame_dst_w[s]);
		dst_height = scaler_pkg::row_t'(frame_dst_h[s]);
		frame_addr = frame_base[s];
		fsync = 1'b1;
		cur_frame = s;
		frame_pixels = frame_dst_w[s] * frame_dst_h[s];
		pix_count = 0;
		done_count = 0;
		@(posedge clk);
		#1 fsync = 1'b0;
		cycles = 0;
		while (pix_count < frame_pixels) begin
			@(posedge clk);
			#1;
			tready = frame_stall[s] ? ($urandom_range(0, 3) != 0) : 1'b1;
			cycles++;
			if (cycles > FRAME_TIMEOUT)
				stop_with_error($sformatf("timeout while frame %s was streaming", frame_name[s]));
		end
		check_flag({frame_name[s], " frame_read_done"}, 1'b1, done_count == 1);
	endtask

	initial begin
		void'($urandom(32'h50b0_7095));
		resetn = 1'b0;
		fsync = 1'b0;
		win_left = '0;
		win_width = '0;
		win_top = '0;
		win_height = '0;
		dst_width = '0;
		dst_height = '0;
		frame_addr = '0;
		tready = 1'b0;
		cur_frame = 0;
		frame_pixels = 0;
		pix_count = 0;
		done_count = 0;
		repeat (2) @(posedge clk);
		#1 resetn = 1'b1;
		tready = 1'b1;
		for (int s = 0; s < N_FRAMES; s++)
			run_frame(s);
		// a short tail catches duplicated pixels after the last frame
		for (int i = 0; i < TAIL_CYCLES; i++) begin
			@(posedge clk);
			#1 tready = 1'b1;
		end
		$display("Done: no errors");
		$finish;
	end

endmodule
